// ==== all.f ====
+incdir+include
verilog/sshooter_pkg.sv
verilog/sshooter_cen.sv
verilog/sound_cmd_latch.sv
verilog/ssg_channel.sv
verilog/audio_mix.sv
verilog/sshooter_sound.sv
dv/tb_sshooter_sound.sv

// ==== run.sh ====
#!/bin/sh
# Builds the sound section testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	-f all.f \
	--top-module tb_sshooter_sound \
	-o tb_sshooter_sound

out=$(./obj_dir/tb_sshooter_sound)
echo "$out"

# The testbench prints the pass line only when every check held
if echo "$out" | grep -q "^Verification passed$"; then
	exit 0
fi
exit 1

// ==== dv/tb_sshooter_sound.sv ====
//====================
// Scooter Shooter sound section testbench
// Checks enable rates, the command latch and interrupt, and the
// sample mixer against a reference model under back-pressure
//====================

`timescale 1ns/1ps

`include "sshooter_defs.svh"

module tb_sshooter_sound;

	import sshooter_pkg::*;

	// Cycle budget per test, summed for the watchdog
	localparam int CEN_CYC     = 1600 + 1572 + 8;
	localparam int CMD_CYC     = 4 * (1600 + 8);
	localparam int STREAM_CYC  = 200 + 40;
	localparam int BP_CYC      = 200 * 8 + 40;
	localparam int RESET_CYC   = 1600 + 40;
	localparam int TIMEOUT_CYC = CEN_CYC + CMD_CYC + STREAM_CYC + BP_CYC + RESET_CYC + 1000;

	logic       clk_49m;
	logic       sirq_clr;
	logic       underclock_i;
	logic       cmd_wr_i;
	logic [7:0] cmd_data_i;
	logic       irq_ack_i;
	logic [7:0] cmd_o;
	logic       sound_irq_o;
	logic       cen_sound_o;
	logic       in_valid_i;
	snd_frame_t in_frame_i;
	logic       in_ready_o;
	logic       out_valid_o;
	logic       out_ready_i;
	sample_t    out_sample_o;

	logic [31:0] lcg_state;
	int          err_cnt;
	int          tests_pass;
	int          tests_fail;
	int          out_cnt;
	int          stall_seen;
	int          cycles;
	logic        acc_now;
	sample_t     exp_q[$];
	sample_t     exp_s;
	// Reference filter state per channel with index 0 for A
	int          ref_avg[3];
	int          ref_lpf[3];

	sshooter_sound dut0 (
		.clk_49m     (clk_49m),
		.sirq_clr    (sirq_clr),
		.underclock_i(underclock_i),
		.cmd_wr_i    (cmd_wr_i),
		.cmd_data_i  (cmd_data_i),
		.irq_ack_i   (irq_ack_i),
		.cmd_o       (cmd_o),
		.sound_irq_o (sound_irq_o),
		.cen_sound_o (cen_sound_o),
		.in_valid_i  (in_valid_i),
		.in_frame_i  (in_frame_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_sample_o(out_sample_o)
	);

	initial begin
		clk_49m = 1'b0;
		forever #5 clk_49m = ~clk_49m;
	end

	//====================
	// Reference model
	//====================

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic snd_frame_t rand_frame();
		logic [31:0] r0;
		logic [31:0] r1;
		snd_frame_t  f;
		r0 = lcg_next();
		r1 = lcg_next();
		f.fm        = sample_t'(r0[31:16]);
		f.ssg_a     = r0[15:8];
		f.ssg_b     = r1[31:24];
		f.ssg_c     = r1[23:16];
		f.filter_en = r1[10:8];
		return f;
	endfunction

	// Advances both filter states of every channel, then forms the weighted mix
	function automatic sample_t mix_model(input snd_frame_t f);
		int          ch;
		int          x;
		int          d;
		int          chan;
		int          sum;
		sample_t     fm_s;
		ssg_raw_t    raw;
		logic [15:0] res;
		fm_s = f.fm;
		sum  = fm_s;
		for (ch = 0; ch < 3; ch++) begin
			case (ch)
				0:       raw = f.ssg_a;
				1:       raw = f.ssg_b;
				default: raw = f.ssg_c;
			endcase
			x = int'(raw) << `SS_SSG_PRESHIFT;
			d = x - ref_avg[ch];
			ref_avg[ch] = ref_avg[ch] + (d >>> `SS_DCRM_SHIFT);
			ref_lpf[ch] = ref_lpf[ch] + ((d - ref_lpf[ch]) >>> `SS_LPF_SHIFT);
			// Filter switch bit 2 belongs to channel A
			if (f.filter_en[2-ch])
				chan = ref_lpf[ch] >>> `SS_SSG_PRESHIFT;
			else
				chan = d >>> `SS_SSG_PRESHIFT;
			sum = sum + `SS_SSG_GAIN * chan;
		end
		res = 16'(sum * 2);
		return sample_t'(res);
	endfunction

	//====================
	// Handshake monitor
	//====================

	// Looks one ns before each rising edge, when inputs and ready/valid are settled
	initial begin
		forever begin
			@(negedge clk_49m);
			#4;
			acc_now = in_valid_i && in_ready_o && !sirq_clr;
			if (acc_now)
				exp_q.push_back(mix_model(in_frame_i));
			if (in_valid_i && !in_ready_o)
				stall_seen++;
			if (out_valid_o && out_ready_i && !sirq_clr) begin
				out_cnt++;
				if (exp_q.size() == 0) begin
					$display("Output sample handed out with no accepted frame behind it");
					err_cnt++;
				end else begin
					exp_s = exp_q.pop_front();
					if (out_sample_o !== exp_s) begin
						$display("Error: out_sample_o got 0x%h expected 0x%h", out_sample_o, exp_s);
						err_cnt++;
					end
				end
			end
		end
	end

	// Watchdog ends a hung run
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk_49m);
			cycles++;
		end
		$display("Run stopped by the watchdog after %0d cycles", cycles);
		$display("Verification failed");
		$finish;
	end

	//====================
	// Stimulus tasks
	//====================

	task automatic apply_reset();
		int ch;
		@(negedge clk_49m);
		sirq_clr   = 1'b1;
		in_valid_i = 1'b0;
		exp_q.delete();
		for (ch = 0; ch < 3; ch++) begin
			ref_avg[ch] = 0;
			ref_lpf[ch] = 0;
		end
		repeat (5) @(negedge clk_49m);
		sirq_clr = 1'b0;
	endtask

	task automatic count_cen(input logic uc, input int n, input int expect_cnt);
		int cnt;
		cnt = 0;
		@(negedge clk_49m);
		underclock_i = uc;
		repeat (n) begin
			@(negedge clk_49m);
			if (cen_sound_o)
				cnt++;
		end
		if (cnt != expect_cnt) begin
			$display("Error: cen_sound_o pulse count 0x%h expected 0x%h", cnt, expect_cnt);
			err_cnt++;
		end
	endtask

	task automatic write_cmd(input logic [7:0] b, input logic uc);
		int wait_cnt;
		@(negedge clk_49m);
		underclock_i = uc;
		cmd_wr_i     = 1'b1;
		cmd_data_i   = b;
		@(negedge clk_49m);
		cmd_wr_i   = 1'b0;
		// Latch must keep the byte after the bus moves on
		cmd_data_i = ~b;
		wait_cnt   = 0;
		while (!sound_irq_o && wait_cnt < 1600) begin
			@(negedge clk_49m);
			wait_cnt++;
		end
		if (!sound_irq_o) begin
			$display("Sound interrupt did not rise within 1600 cycles of the write");
			err_cnt++;
		end
		if (cmd_o !== b) begin
			$display("Error: cmd_o got 0x%h expected 0x%h", cmd_o, b);
			err_cnt++;
		end
		irq_ack_i = 1'b1;
		@(negedge clk_49m);
		irq_ack_i = 1'b0;
		@(negedge clk_49m);
		if (sound_irq_o !== 1'b0) begin
			$display("Error: sound_irq_o got 0x%h expected 0x0", sound_irq_o);
			err_cnt++;
		end
	endtask

	// Holds each frame until the monitor sees it accepted
	task automatic send_frames(input int n, input bit stall);
		int          sent;
		logic [31:0] r;
		sent = 0;
		@(negedge clk_49m);
		while (sent < n) begin
			in_valid_i = 1'b1;
			in_frame_i = rand_frame();
			r = lcg_next();
			out_ready_i = stall ? r[29] : 1'b1;
			@(negedge clk_49m);
			while (!acc_now) begin
				r = lcg_next();
				out_ready_i = stall ? r[29] : 1'b1;
				@(negedge clk_49m);
			end
			sent++;
		end
		in_valid_i = 1'b0;
	endtask

	task automatic drain(input int expect_out, input int base_out);
		int n;
		out_ready_i = 1'b1;
		n = 0;
		while ((exp_q.size() != 0 || out_valid_o) && n < 20) begin
			@(negedge clk_49m);
			n++;
		end
		if (exp_q.size() != 0 || out_cnt - base_out != expect_out) begin
			$display("Sample count wrong, %0d frames sent and %0d samples came out",
				expect_out, out_cnt - base_out);
			err_cnt++;
		end
	endtask

	task automatic report(input string name, input int err_before);
		if (err_cnt == err_before) begin
			tests_pass++;
			$display("Test %s: pass", name);
		end else begin
			tests_fail++;
			$display("Test %s: FAIL with %0d errors", name, err_cnt - err_before);
		end
	endtask

	//====================
	// Test sequence
	//====================

	initial begin
		int e0;
		int o0;
		int n;
		lcg_state    = 32'd76;
		err_cnt      = 0;
		tests_pass   = 0;
		tests_fail   = 0;
		out_cnt      = 0;
		stall_seen   = 0;
		acc_now      = 1'b0;
		sirq_clr     = 1'b1;
		underclock_i = 1'b0;
		cmd_wr_i     = 1'b0;
		cmd_data_i   = '0;
		irq_ack_i    = 1'b0;
		in_valid_i   = 1'b0;
		in_frame_i   = '0;
		out_ready_i  = 1'b1;
		apply_reset();

		e0 = err_cnt;
		count_cen(1'b0, 1600, 100);
		count_cen(1'b1, 1572, 100);
		report("enable rates", e0);

		e0 = err_cnt;
		write_cmd(8'h5a, 1'b0);
		write_cmd(8'hc3, 1'b1);
		write_cmd(8'h01, 1'b1);
		write_cmd(8'hfe, 1'b0);
		report("command latch", e0);

		e0 = err_cnt;
		o0 = out_cnt;
		send_frames(200, 1'b0);
		drain(200, o0);
		report("streaming mix", e0);

		e0 = err_cnt;
		o0 = out_cnt;
		stall_seen = 0;
		send_frames(200, 1'b1);
		drain(200, o0);
		if (stall_seen == 0) begin
			$display("in_ready_o never fell while the output was stalled");
			err_cnt++;
		end
		report("back-pressure", e0);

		// Filter state is far from zero here
		// An unacknowledged command and a stalled output then leave the interrupt
		// raised and both pipeline stages full before the reset
		e0 = err_cnt;
		@(negedge clk_49m);
		cmd_wr_i    = 1'b1;
		cmd_data_i  = 8'h3c;
		out_ready_i = 1'b0;
		in_valid_i  = 1'b1;
		in_frame_i  = rand_frame();
		@(negedge clk_49m);
		cmd_wr_i = 1'b0;
		n = 0;
		while ((!sound_irq_o || in_ready_o) && n < 1600) begin
			@(negedge clk_49m);
			n++;
		end
		if (!sound_irq_o || in_ready_o) begin
			$display("Interrupt did not rise or the pipeline did not fill before the reset");
			err_cnt++;
		end
		@(negedge clk_49m);
		sirq_clr = 1'b1;
		apply_reset();
		if (sound_irq_o !== 1'b0 || out_valid_o !== 1'b0 || in_ready_o !== 1'b1
			|| cen_sound_o !== 1'b0) begin
			$display("Outputs not in their reset state after reset");
			err_cnt++;
		end
		o0 = out_cnt;
		send_frames(1, 1'b0);
		drain(1, o0);
		report("reset state", e0);

		$display("Tests passed %0d, failed %0d, errors %0d", tests_pass, tests_fail, err_cnt);
		if (err_cnt == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== verilog/sshooter_sound.sv ====
//====================
// Scooter Shooter sound section
// Enable generator, sound command latch and the final
// audio mixer
//====================

`timescale 1ns/1ps

module sshooter_sound (
	input  logic                     clk_49m,
	input  logic                     sirq_clr,
	// Selects the fractional sound enable for underclocked video timing
	input  logic                     underclock_i,

	// Main CPU side of the sound latch
	input  logic                     cmd_wr_i,
	input  logic [7:0]               cmd_data_i,
	input  logic                     irq_ack_i,
	output logic [7:0]               cmd_o,
	output logic                     sound_irq_o,
	output logic                     cen_sound_o,

	// Sample frames in, mixed audio out
	input  logic                     in_valid_i,
	input  sshooter_pkg::snd_frame_t in_frame_i,
	output logic                     in_ready_o,
	output logic                     out_valid_o,
	input  logic                     out_ready_i,
	output sshooter_pkg::sample_t    out_sample_o
);

	logic cen_3m;
	logic cen_sound;

	//====================
	// Clock enables
	//====================

	sshooter_cen cen0 (
		.clk_49m     (clk_49m),
		.sirq_clr    (sirq_clr),
		.underclock_i(underclock_i),
		.cen_3m_o    (cen_3m),
		.cen_sound_o (cen_sound)
	);

	// The sound CPU and YM2203 run off this enable outside the block
	assign cen_sound_o = cen_sound;

	//====================
	// Command latch
	//====================

	sound_cmd_latch latch0 (
		.clk_49m    (clk_49m),
		.sirq_clr   (sirq_clr),
		.cen_3m_i   (cen_3m),
		.cen_sound_i(cen_sound),
		.cmd_wr_i   (cmd_wr_i),
		.cmd_data_i (cmd_data_i),
		.irq_ack_i  (irq_ack_i),
		.cmd_o      (cmd_o),
		.sound_irq_o(sound_irq_o)
	);

	// Mixer is paced by frame handshakes, not by the enables
	audio_mix mix0 (
		.clk_49m     (clk_49m),
		.sirq_clr    (sirq_clr),
		.in_valid_i  (in_valid_i),
		.in_frame_i  (in_frame_i),
		.in_ready_o  (in_ready_o),
		.out_valid_o (out_valid_o),
		.out_ready_i (out_ready_i),
		.out_sample_o(out_sample_o)
	);

endmodule

// ==== verilog/audio_mix.sv ====
//====================
// Audio mixer pipeline
// Conditions the three SSG channels and mixes them with the
// FM sample over two valid/ready stages
//====================

`timescale 1ns/1ps

`include "sshooter_defs.svh"

module audio_mix (
	input  logic                    clk_49m,
	input  logic                    sirq_clr,
	input  logic                    in_valid_i,
	input  sshooter_pkg::snd_frame_t in_frame_i,
	output logic                    in_ready_o,
	output logic                    out_valid_o,
	input  logic                    out_ready_i,
	output sshooter_pkg::sample_t    out_sample_o
);

	import sshooter_pkg::*;

	// Headroom for fm plus three weighted channels before the final shift
	localparam int MIX_W = `SS_SAMPLE_W + 4;

	typedef logic signed [MIX_W-1:0] mix_t;

	localparam mix_t SSG_GAIN = mix_t'(`SS_SSG_GAIN);

	logic    accept;
	logic    s1_valid;
	sample_t s1_fm;
	sample_t ssg_a;
	sample_t ssg_b;
	sample_t ssg_c;
	logic    s2_ready;
	logic    s1_move;
	mix_t    mix_sum;
	logic    s2_valid;
	sample_t s2_sample;

	//====================
	// Flow control
	//====================

	// Stage 2 frees up when it is empty or its sample is being taken
	assign s2_ready   = ~s2_valid | out_ready_i;
	assign s1_move    = s1_valid & s2_ready;
	assign in_ready_o = ~s1_valid | s2_ready;
	assign accept     = in_valid_i & in_ready_o;

	//====================
	// Stage 1
	//====================

	// Channel registers inside each instance form the rest of stage 1
	ssg_channel ch_a (.clk_49m(clk_49m), .sirq_clr(sirq_clr), .step_i(accept),
		.raw_i(in_frame_i.ssg_a), .filt_en_i(in_frame_i.filter_en[2]), .out_o(ssg_a));
	ssg_channel ch_b (.clk_49m(clk_49m), .sirq_clr(sirq_clr), .step_i(accept),
		.raw_i(in_frame_i.ssg_b), .filt_en_i(in_frame_i.filter_en[1]), .out_o(ssg_b));
	ssg_channel ch_c (.clk_49m(clk_49m), .sirq_clr(sirq_clr), .step_i(accept),
		.raw_i(in_frame_i.ssg_c), .filt_en_i(in_frame_i.filter_en[0]), .out_o(ssg_c));

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			s1_valid <= 1'b0;
			s1_fm    <= '0;
		end else begin
			if (accept)
				s1_fm <= in_frame_i.fm;
			// Stage empties only if it moves on and nothing new arrives
			if (accept)
				s1_valid <= 1'b1;
			else if (s1_move)
				s1_valid <= 1'b0;
		end
	end

	//====================
	// Stage 2
	//====================

	assign mix_sum = mix_t'(s1_fm) + SSG_GAIN * mix_t'(ssg_a) + SSG_GAIN * mix_t'(ssg_b)
		+ SSG_GAIN * mix_t'(ssg_c);

	// Doubled and cut to 16 bits, wrapping just like the board mix
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			s2_valid  <= 1'b0;
			s2_sample <= '0;
		end else if (s2_ready) begin
			s2_valid <= s1_valid;
			if (s1_valid)
				s2_sample <= {mix_sum[`SS_SAMPLE_W-2:0], 1'b0};
		end
	end

	assign out_valid_o  = s2_valid;
	assign out_sample_o = s2_sample;

endmodule

// ==== verilog/ssg_channel.sv ====
//====================
// SSG channel conditioning
// DC removal, switchable one-pole low-pass filter and
// attenuation back to raw level
//====================

`timescale 1ns/1ps

`include "sshooter_defs.svh"

module ssg_channel (
	input  logic                 clk_49m,
	input  logic                 sirq_clr,
	input  logic                 step_i,
	input  sshooter_pkg::ssg_raw_t raw_i,
	input  logic                 filt_en_i,
	output sshooter_pkg::sample_t  out_o
);

	import sshooter_pkg::*;

	localparam int PAD_W = `SS_SAMPLE_W - `SS_SSG_RAW_W - `SS_SSG_PRESHIFT;

	sample_t x;
	sample_t dc_avg;
	sample_t dc_out;
	sample_t lpf_y;
	sample_t lpf_next;
	sample_t sel;
	sample_t out_q;

	//====================
	// DC removal
	//====================

	// Gain first, so quiet levels survive the filter arithmetic
	assign x = {{PAD_W{1'b0}}, raw_i, {`SS_SSG_PRESHIFT{1'b0}}};

	// Output is taken against the average from before this step
	assign dc_out = x - dc_avg;

	//====================
	// Low-pass filter
	//====================

	// y moves an eighth of the way toward the DC-free input each step
	assign lpf_next = lpf_y + ((dc_out - lpf_y) >>> `SS_LPF_SHIFT);

	// The filter always runs, the switch only picks which signal goes out
	// This mirrors the 74HC4066 bypass on the board
	assign sel = filt_en_i ? lpf_next : dc_out;

	// All state moves together once per accepted frame
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			dc_avg <= '0;
			lpf_y  <= '0;
			out_q  <= '0;
		end else if (step_i) begin
			// Leaky average, same as adding (x - avg) >>> shift
			dc_avg <= dc_avg + (dc_out >>> `SS_DCRM_SHIFT);
			lpf_y  <= lpf_next;
			// Arithmetic shift keeps the sign of the swing around zero
			out_q  <= sel >>> `SS_SSG_PRESHIFT;
		end
	end

	// Held value is the stage 1 slot for this channel
	assign out_o = out_q;

endmodule

// ==== verilog/sound_cmd_latch.sv ====
//====================
// Sound command latch
// Holds the byte from the main CPU and raises the sound
// CPU interrupt until it is acknowledged
//====================

`timescale 1ns/1ps

`include "sshooter_defs.svh"

module sound_cmd_latch (
	input  logic                 clk_49m,
	input  logic                 sirq_clr,
	input  logic                 cen_3m_i,
	input  logic                 cen_sound_i,
	input  logic                 cmd_wr_i,
	input  logic [`SS_CMD_W-1:0] cmd_data_i,
	input  logic                 irq_ack_i,
	output logic [`SS_CMD_W-1:0] cmd_o,
	output logic                 sound_irq_o
);

	import sshooter_pkg::*;

	irq_state_t           state_q;
	logic                 wr_pend_q;
	logic [`SS_CMD_W-1:0] pend_data_q;
	logic [`SS_CMD_W-1:0] cmd_q;
	logic                 take_cmd;

	// The board bus writes the latch on the 3.072 MHz phase
	assign take_cmd = cen_3m_i & wr_pend_q;

	// Bus strobe is one cycle wide, so the byte waits here for the enable
	// A strobe that lands together with take_cmd stays pending for the next one
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			wr_pend_q   <= 1'b0;
			pend_data_q <= '0;
		end else if (cmd_wr_i) begin
			wr_pend_q   <= 1'b1;
			pend_data_q <= cmd_data_i;
		end else if (take_cmd) begin
			wr_pend_q <= 1'b0;
		end
	end

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr)
			cmd_q <= '0;
		else if (take_cmd)
			cmd_q <= pend_data_q;
	end

	//====================
	// Interrupt FSM
	//====================

	// A command taken in the same cycle as an acknowledge starts a new request
	// Otherwise the acknowledge from the sound CPU clears from any state
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr)
			state_q <= IRQ_IDLE;
		else if (take_cmd)
			state_q <= IRQ_PENDING;
		else if (irq_ack_i)
			state_q <= IRQ_IDLE;
		else if (state_q == IRQ_PENDING && cen_sound_i)
			state_q <= IRQ_ASSERTED;
	end

	assign cmd_o       = cmd_q;
	assign sound_irq_o = (state_q == IRQ_ASSERTED);

endmodule

// ==== verilog/sshooter_cen.sv ====
//====================
// Sound clock enables
// Integer 3.072 MHz enable and a fractional enable that keeps
// the sound pitch right when the board runs underclocked
//====================

`timescale 1ns/1ps

`include "sshooter_defs.svh"

module sshooter_cen (
	input  logic clk_49m,
	input  logic sirq_clr,
	input  logic underclock_i,
	output logic cen_3m_o,
	output logic cen_sound_o
);

	localparam int CNT_W = $clog2(`SS_CEN3M_DIV);
	// One spare bit so the sum before the wrap check never overflows
	localparam int ACC_W = $clog2(`SS_FRAC_M) + 1;

	logic [CNT_W-1:0] div_cnt;
	logic             cen_3m_q;
	logic [ACC_W-1:0] frac_acc;
	logic [ACC_W-1:0] frac_sum;
	logic             cen_frac_q;

	//====================
	// Integer divider
	//====================

	// Counter runs 0 to DIV-1 and the enable is registered on the last count
	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			div_cnt  <= '0;
			cen_3m_q <= 1'b0;
		end else begin
			cen_3m_q <= (div_cnt == CNT_W'(`SS_CEN3M_DIV - 1));
			if (div_cnt == CNT_W'(`SS_CEN3M_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

	//====================
	// Fractional divider
	//====================

	// Adds N every cycle and pulses whenever the sum crosses M
	assign frac_sum = frac_acc + ACC_W'(`SS_FRAC_N);

	always_ff @(posedge clk_49m or posedge sirq_clr) begin
		if (sirq_clr) begin
			frac_acc   <= '0;
			cen_frac_q <= 1'b0;
		end else if (frac_sum >= ACC_W'(`SS_FRAC_M)) begin
			frac_acc   <= frac_sum - ACC_W'(`SS_FRAC_M);
			cen_frac_q <= 1'b1;
		end else begin
			frac_acc   <= frac_sum;
			cen_frac_q <= 1'b0;
		end
	end

	assign cen_3m_o = cen_3m_q;
	// Underclocked timing needs the fractional enable to hold the YM2203 pitch
	assign cen_sound_o = underclock_i ? cen_frac_q : cen_3m_q;

endmodule

// ==== verilog/sshooter_pkg.sv ====
//====================
// Scooter Shooter sound types
// Sample words, the input frame bundle and the sound
// interrupt states
//====================

`include "sshooter_defs.svh"

package sshooter_pkg;

	// Signed sample as produced by the FM side and the mixer
	typedef logic signed [`SS_SAMPLE_W-1:0] sample_t;

	// Unsigned level of one SSG tone channel
	typedef logic [`SS_SSG_RAW_W-1:0] ssg_raw_t;

	//====================
	// Input sample frame
	//====================

	// One frame carries everything the mixer needs for one output sample
	// The filter switches come from the YM2203 port A outputs on the board
	typedef struct packed {
		sample_t    fm;
		ssg_raw_t   ssg_a;
		ssg_raw_t   ssg_b;
		ssg_raw_t   ssg_c;
		// Bit 2 switches channel A, bit 1 channel B, bit 0 channel C
		logic [2:0] filter_en;
	} snd_frame_t;

	// Sound interrupt progress from latch write to acknowledge
	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_PENDING,
		IRQ_ASSERTED
	} irq_state_t;

endpackage

// ==== include/sshooter_defs.svh ====
//====================
// Scooter Shooter sound section constants
// Sample widths, filter shifts, mixer weight and the clock-enable
// divider ratios shared by the sound RTL
//====================

`ifndef SSHOOTER_DEFS_SVH
`define SSHOOTER_DEFS_SVH

// Signed audio sample width used through the whole sample path
`define SS_SAMPLE_W 16

// Raw SSG channel output width from the YM2203
`define SS_SSG_RAW_W 8

// Gain applied before DC removal and filtering, undone again afterwards
`define SS_SSG_PRESHIFT 5

// Leak of the running DC average
`define SS_DCRM_SHIFT 4

// One-pole low-pass coefficient as a power of two
`define SS_LPF_SHIFT 3

// Weight of each SSG channel against the FM sample in the final mix
`define SS_SSG_GAIN 21

// Main CPU to sound CPU command byte
`define SS_CMD_W 8

// 49.152 MHz divided by 16 gives the 3.072 MHz enable
`define SS_CEN3M_DIV 16

// Fractional enable, 50 pulses in every 786 cycles for underclocked timing
`define SS_FRAC_N 50
`define SS_FRAC_M 786

`endif
